/* design/rp_pkg.sv */
// Shared bus, region and channel constants, bus address union
`default_nettype none

package rp_pkg;

  ////////////////////////////////////////////////////////////
  // System bus geometry
  ////////////////////////////////////////////////////////////

  localparam int unsigned SYS_DW       = 32;
  localparam int unsigned SYS_AW       = 32;
  // 16 regions of 1 MB each
  localparam int unsigned SYS_REGION_W = 4;
  localparam int unsigned SYS_OFFSET_W = 20;
  // Upper address bits, not decoded
  localparam int unsigned SYS_RSV_W    = SYS_AW - SYS_REGION_W - SYS_OFFSET_W;

  // Region map
  localparam logic [SYS_REGION_W-1:0] REG_ID  = 4'd0;
  localparam logic [SYS_REGION_W-1:0] REG_PDM = 4'd1;
  localparam logic [SYS_REGION_W-1:0] REG_DAC = 4'd2;
  localparam logic [SYS_REGION_W-1:0] REG_ADC = 4'd3;

  ////////////////////////////////////////////////////////////
  // Analog channels
  ////////////////////////////////////////////////////////////

  localparam int unsigned ADC_CHN = 2;
  localparam int unsigned ADC_DW  = 16;
  localparam int unsigned DAC_CHN = 2;
  localparam int unsigned DAC_DW  = 14;
  localparam int unsigned PDM_CHN = 4;
  localparam int unsigned PDM_DW  = 8;

  // Identification words in region 0
  localparam logic [SYS_DW-1:0] ID_WORD      = 32'h5270_4146;
  // Channel counts, one per byte
  localparam logic [SYS_DW-1:0] FEATURE_WORD = {8'h00, 8'(PDM_CHN), 8'(DAC_CHN), 8'(ADC_CHN)};

  // Largest positive DAC code
  localparam logic [DAC_DW-1:0] DAC_IDLE_CODE = {1'b0, {(DAC_DW-1){1'b1}}};

  // Bus address, either as raw word or split into fields
  typedef union packed {
    logic [SYS_AW-1:0] word;
    struct packed {
      logic [SYS_RSV_W-1:0]    reserved;
      logic [SYS_REGION_W-1:0] region;
      // Byte address inside the region
      logic [SYS_OFFSET_W-1:0] offset;
    } fields;
  } sys_addr_u;

endpackage

`default_nettype wire

/* design/sys_bus_decoder.sv */
// System bus region decoder with identification words and registered acknowledge
`default_nettype none
`timescale 1ns/1ps

module sys_bus_decoder (
  input  logic                            adc_clk,
  input  logic                            top_rst,
  // Bus from master
  input  rp_pkg::sys_addr_u               sys_addr_i,
  input  logic [rp_pkg::SYS_DW-1:0]       sys_wdata_i,
  input  logic                            sys_wen_i,
  input  logic                            sys_ren_i,
  // Read words from region modules
  input  logic [rp_pkg::SYS_DW-1:0]       pdm_rdata_i,
  input  logic [rp_pkg::SYS_DW-1:0]       dac_rdata_i,
  input  logic [rp_pkg::SYS_DW-1:0]       adc_rdata_i,
  // Bus to master
  output logic [rp_pkg::SYS_DW-1:0]       sys_rdata_o,
  output logic                            sys_ack_o,
  // Shared towards region modules
  output logic [rp_pkg::SYS_OFFSET_W-1:0] offset_o,
  output logic [rp_pkg::SYS_DW-1:0]       wdata_o,
  // Per region write strobes
  output logic                            pdm_wen_o,
  output logic                            dac_wen_o
);

  import rp_pkg::*;

  logic [SYS_REGION_W-1:0] region;
  logic [SYS_OFFSET_W-1:0] offset;
  logic [SYS_DW-1:0]       id_rdata;
  logic [SYS_DW-1:0]       rd_mux;

  ////////////////////////////////////////////////////////////
  // Address split and write strobes
  ////////////////////////////////////////////////////////////

  assign region = sys_addr_i.fields.region;
  assign offset = sys_addr_i.fields.offset;

  // Offset and data go to every region
  assign offset_o = offset;
  assign wdata_o  = sys_wdata_i;

  // Only the addressed region sees the strobe
  assign pdm_wen_o = sys_wen_i && (region == REG_PDM);
  assign dac_wen_o = sys_wen_i && (region == REG_DAC);

  ////////////////////////////////////////////////////////////
  // Region 0 identification
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (offset)
      SYS_OFFSET_W'(0): id_rdata = ID_WORD;
      SYS_OFFSET_W'(4): id_rdata = FEATURE_WORD;
      // Rest of region 0 is empty
      default:          id_rdata = '0;
    endcase
  end

  // Read word select by region
  always_comb begin
    case (region)
      REG_ID:  rd_mux = id_rdata;
      REG_PDM: rd_mux = pdm_rdata_i;
      REG_DAC: rd_mux = dac_rdata_i;
      REG_ADC: rd_mux = adc_rdata_i;
      // Unmapped regions
      default: rd_mux = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Acknowledge and read data registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      sys_ack_o   <= 1'b0;
      sys_rdata_o <= '0;
    end else begin
      // Every strobe is answered one cycle later
      sys_ack_o <= sys_wen_i || sys_ren_i;
      if (sys_wen_i) begin
        sys_rdata_o <= '0;
      end else if (sys_ren_i) begin
        sys_rdata_o <= rd_mux;
      end
    end
  end

endmodule

`default_nettype wire

/* design/adc_frontend.sv */
// ADC pin capture, negative slope to two's complement conversion, sample readback
`default_nettype none
`timescale 1ns/1ps

module adc_frontend (
  input  logic                                          adc_clk,
  input  logic                                          top_rst,
  // Converter pins
  input  logic [rp_pkg::ADC_CHN-1:0][rp_pkg::ADC_DW-1:0] adc_dat_i,
  // Bus read side
  input  logic [rp_pkg::SYS_OFFSET_W-1:0]               offset_i,
  output logic [rp_pkg::SYS_DW-1:0]                     rdata_o
);

  import rp_pkg::*;

  logic [ADC_CHN-1:0][ADC_DW-1:0] adc_raw;
  logic [ADC_CHN-1:0][ADC_DW-1:0] adc_smp;
  logic [SYS_OFFSET_W-3:0]        reg_idx;

  ////////////////////////////////////////////////////////////
  // Input registers
  ////////////////////////////////////////////////////////////

  // Sample pins every cycle
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      adc_raw <= '0;
    end else begin
      adc_raw <= adc_dat_i;
    end
  end

  // Sign bit kept, magnitude bits inverted
  always_comb begin
    for (int n = 0; n < ADC_CHN; n++) begin
      adc_smp[n] = {adc_raw[n][ADC_DW-1], ~adc_raw[n][ADC_DW-2:0]};
    end
  end

  ////////////////////////////////////////////////////////////
  // Readback
  ////////////////////////////////////////////////////////////

  // Word index within region
  assign reg_idx = offset_i[SYS_OFFSET_W-1:2];

  always_comb begin
    rdata_o = '0;
    for (int n = 0; n < ADC_CHN; n++) begin
      if (reg_idx == n) begin
        // Sign extend to bus width
        rdata_o = {{(SYS_DW-ADC_DW){adc_smp[n][ADC_DW-1]}}, adc_smp[n]};
      end
    end
  end

endmodule

`default_nettype wire

/* design/dac_backend.sv */
// DAC value registers, output code conversion and value readback
`default_nettype none
`timescale 1ns/1ps

module dac_backend (
  input  logic                                          adc_clk,
  input  logic                                          top_rst,
  // Bus write side
  input  logic                                          wen_i,
  input  logic [rp_pkg::SYS_OFFSET_W-1:0]               offset_i,
  input  logic [rp_pkg::SYS_DW-1:0]                     wdata_i,
  // Bus read side
  output logic [rp_pkg::SYS_DW-1:0]                     rdata_o,
  // Converter code per channel
  output logic [rp_pkg::DAC_CHN-1:0][rp_pkg::DAC_DW-1:0] dac_dat_o
);

  import rp_pkg::*;

  // Signed values as written by software
  logic [DAC_CHN-1:0][DAC_DW-1:0] dac_val;
  logic [SYS_OFFSET_W-3:0]        reg_idx;

  assign reg_idx = offset_i[SYS_OFFSET_W-1:2];

  ////////////////////////////////////////////////////////////
  // Value registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      dac_val <= '0;
    end else if (wen_i) begin
      for (int n = 0; n < DAC_CHN; n++) begin
        // Low bits only, upper write data ignored
        if (reg_idx == n) begin
          dac_val[n] <= wdata_i[DAC_DW-1:0];
        end
      end
    end
  end

  // Output code, one cycle behind the value
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      dac_dat_o <= {DAC_CHN{DAC_IDLE_CODE}};
    end else begin
      for (int n = 0; n < DAC_CHN; n++) begin
        // Negative slope code, sign kept
        dac_dat_o[n] <= {dac_val[n][DAC_DW-1], ~dac_val[n][DAC_DW-2:0]};
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Readback
  ////////////////////////////////////////////////////////////

  always_comb begin
    rdata_o = '0;
    for (int n = 0; n < DAC_CHN; n++) begin
      if (reg_idx == n) begin
        rdata_o = {{(SYS_DW-DAC_DW){dac_val[n][DAC_DW-1]}}, dac_val[n]};
      end
    end
  end

endmodule

`default_nettype wire

/* design/pdm_dac.sv */
// PDM configuration registers and first-order pulse density modulators
`default_nettype none
`timescale 1ns/1ps

module pdm_dac (
  input  logic                            adc_clk,
  input  logic                            top_rst,
  // Bus write side
  input  logic                            wen_i,
  input  logic [rp_pkg::SYS_OFFSET_W-1:0] offset_i,
  input  logic [rp_pkg::SYS_DW-1:0]       wdata_i,
  // Bus read side
  output logic [rp_pkg::SYS_DW-1:0]       rdata_o,
  // One bit outputs to RC filters
  output logic [rp_pkg::PDM_CHN-1:0]      dac_pwm_o
);

  import rp_pkg::*;

  logic [PDM_CHN-1:0][PDM_DW-1:0] pdm_cfg;
  logic [PDM_CHN-1:0][PDM_DW-1:0] pdm_acc;
  // Accumulator sum with carry on top
  logic [PDM_CHN-1:0][PDM_DW:0]   pdm_sum;
  logic [SYS_OFFSET_W-3:0]        reg_idx;

  assign reg_idx = offset_i[SYS_OFFSET_W-1:2];

  ////////////////////////////////////////////////////////////
  // Configuration registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      pdm_cfg <= '0;
    end else if (wen_i) begin
      for (int n = 0; n < PDM_CHN; n++) begin
        if (reg_idx == n) begin
          pdm_cfg[n] <= wdata_i[PDM_DW-1:0];
        end
      end
    end
  end

  // Zero extended readback
  always_comb begin
    rdata_o = '0;
    for (int n = 0; n < PDM_CHN; n++) begin
      if (reg_idx == n) begin
        rdata_o = {{(SYS_DW-PDM_DW){1'b0}}, pdm_cfg[n]};
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Modulators
  ////////////////////////////////////////////////////////////

  always_comb begin
    for (int n = 0; n < PDM_CHN; n++) begin
      pdm_sum[n] = {1'b0, pdm_acc[n]} + {1'b0, pdm_cfg[n]};
    end
  end

  // Carry out gives v pulses per 256 cycles
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      pdm_acc   <= '0;
      dac_pwm_o <= '0;
    end else begin
      for (int n = 0; n < PDM_CHN; n++) begin
        pdm_acc[n]   <= pdm_sum[n][PDM_DW-1:0];
        dac_pwm_o[n] <= pdm_sum[n][PDM_DW];
      end
    end
  end

endmodule

`default_nettype wire

/* design/rp_top.sv */
// Analog front end top level with bus decoder, ADC, DAC and PDM instances
`default_nettype none
`timescale 1ns/1ps

module rp_top (
  input  logic                                          adc_clk,
  input  logic                                          top_rst,
  // ADC
  input  logic [rp_pkg::ADC_CHN-1:0][rp_pkg::ADC_DW-1:0] adc_dat_i,
  output logic                                          adc_cdcs_o,
  // System bus
  input  rp_pkg::sys_addr_u                             sys_addr_i,
  input  logic [rp_pkg::SYS_DW-1:0]                     sys_wdata_i,
  input  logic                                          sys_wen_i,
  input  logic                                          sys_ren_i,
  output logic [rp_pkg::SYS_DW-1:0]                     sys_rdata_o,
  output logic                                          sys_ack_o,
  // DAC, one port per channel
  output logic [rp_pkg::DAC_CHN-1:0][rp_pkg::DAC_DW-1:0] dac_dat_o,
  // PDM
  output logic [rp_pkg::PDM_CHN-1:0]                    dac_pwm_o
);

  import rp_pkg::*;

  logic [SYS_OFFSET_W-1:0] bus_offset;
  logic [SYS_DW-1:0]       bus_wdata;
  logic                    pdm_wen;
  logic                    dac_wen;
  logic [SYS_DW-1:0]       pdm_rdata;
  logic [SYS_DW-1:0]       dac_rdata;
  logic [SYS_DW-1:0]       adc_rdata;

  // Duty cycle stabilizer enabled
  assign adc_cdcs_o = 1'b1;

  ////////////////////////////////////////////////////////////
  // Bus decoder and identification
  ////////////////////////////////////////////////////////////

  sys_bus_decoder u_sys_bus_decoder (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .pdm_rdata_i (pdm_rdata),
    .dac_rdata_i (dac_rdata),
    .adc_rdata_i (adc_rdata),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .offset_o    (bus_offset),
    .wdata_o     (bus_wdata),
    .pdm_wen_o   (pdm_wen),
    .dac_wen_o   (dac_wen)
  );

  // ADC IO, read only region
  adc_frontend u_adc_frontend (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .adc_dat_i (adc_dat_i),
    .offset_i  (bus_offset),
    .rdata_o   (adc_rdata)
  );

  // DAC IO
  dac_backend u_dac_backend (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .wen_i     (dac_wen),
    .offset_i  (bus_offset),
    .wdata_i   (bus_wdata),
    .rdata_o   (dac_rdata),
    .dac_dat_o (dac_dat_o)
  );

  // PDM with its register set
  pdm_dac u_pdm_dac (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .wen_i     (pdm_wen),
    .offset_i  (bus_offset),
    .wdata_i   (bus_wdata),
    .rdata_o   (pdm_rdata),
    .dac_pwm_o (dac_pwm_o)
  );

endmodule

`default_nettype wire

/* tests/tb_clock.sv */
// Testbench clock and reset generator
`default_nettype none
`timescale 1ns/1ps

module tb_clock (
  output logic clk_o,
  output logic rst_o
);

  // 20 ns period
  localparam int HALF_PERIOD = 10;
  localparam int RST_CYCLES  = 4;

  initial begin
    clk_o = 1'b0;
    forever begin
      #(HALF_PERIOD) clk_o = ~clk_o;
    end
  end

  // Reset held for 4 cycles, released on a falling edge
  initial begin
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule

`default_nettype wire

/* tests/tb_rp_top.sv */
// Directed tests for the analog front end top level, LFSR, compare tasks
`default_nettype none
`timescale 1ns/1ps

module tb_rp_top;

  import rp_pkg::*;

  localparam int ACK_TIMEOUT = 8;
  localparam int RST_TIMEOUT = 20;
  // Expected constants from the register map
  localparam logic [DAC_DW-1:0] IDLE_EXP    = 14'h1fff;
  localparam logic [SYS_DW-1:0] FEATURE_EXP = 32'h0004_0202;

  logic                           adc_clk;
  logic                           top_rst;
  logic [ADC_CHN-1:0][ADC_DW-1:0] adc_dat;
  sys_addr_u                      sys_addr;
  logic [SYS_DW-1:0]              sys_wdata;
  logic                           sys_wen;
  logic                           sys_ren;
  logic [SYS_DW-1:0]              sys_rdata;
  logic                           sys_ack;
  logic [DAC_CHN-1:0][DAC_DW-1:0] dac_dat;
  logic [PDM_CHN-1:0]             dac_pwm;
  logic                           adc_cdcs;
  logic [31:0]                    lfsr_state;

  tb_clock u_clock (
    .clk_o (adc_clk),
    .rst_o (top_rst)
  );

  rp_top DUT (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .adc_dat_i   (adc_dat),
    .adc_cdcs_o  (adc_cdcs),
    .sys_addr_i  (sys_addr),
    .sys_wdata_i (sys_wdata),
    .sys_wen_i   (sys_wen),
    .sys_ren_i   (sys_ren),
    .sys_rdata_o (sys_rdata),
    .sys_ack_o   (sys_ack),
    .dac_dat_o   (dac_dat),
    .dac_pwm_o   (dac_pwm)
  );

  ////////////////////////////////////////////////////////////
  // Random bits and failure handling
  ////////////////////////////////////////////////////////////

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] draw_bits(input int nbits);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val = {val[30:0], lfsr_state[31]};
    end
    return val;
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_word(input logic [SYS_DW-1:0] got, input logic [SYS_DW-1:0] exp,
                            input string what);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_dac_code(input logic [DAC_DW-1:0] got, input logic [DAC_DW-1:0] exp,
                                input string what);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_pulse_count(input int got, input int exp, input string what);
    if (got != exp) begin
      abort_run($sformatf("[ERROR] %0t: %s got %0d expected %0d", $time, what, got, exp));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Bus access
  ////////////////////////////////////////////////////////////

  // Sampled on rising edges, reset moves on falling ones
  task automatic wait_reset_release();
    int waited;
    waited = 0;
    @(posedge adc_clk);
    while (top_rst && waited < RST_TIMEOUT) begin
      @(posedge adc_clk);
      waited++;
    end
    if (top_rst) begin
      abort_run("Reset was never released");
    end
    @(negedge adc_clk);
  endtask

  task automatic await_ack();
    int waited;
    waited = 0;
    while (!sys_ack && waited < ACK_TIMEOUT) begin
      @(negedge adc_clk);
      waited++;
    end
    if (!sys_ack) begin
      abort_run("No acknowledge arrived within 8 cycles of a bus strobe");
    end
  endtask

  // Called on a falling edge, returns on the falling edge of the ack cycle
  task automatic bus_write(input logic [SYS_REGION_W-1:0] region,
                           input logic [SYS_OFFSET_W-1:0] offset, input logic [SYS_DW-1:0] data);
    sys_addr.word          = '0;
    sys_addr.fields.region = region;
    sys_addr.fields.offset = offset;
    sys_wdata              = data;
    sys_wen                = 1'b1;
    @(negedge adc_clk);
    sys_wen = 1'b0;
    await_ack();
    // Read word is zero in a write ack
    check_word(sys_rdata, '0, "Read data during write ack");
  endtask

  task automatic bus_read(input logic [SYS_REGION_W-1:0] region,
                          input logic [SYS_OFFSET_W-1:0] offset, output logic [SYS_DW-1:0] data);
    sys_addr.word          = '0;
    sys_addr.fields.region = region;
    sys_addr.fields.offset = offset;
    sys_ren                = 1'b1;
    @(negedge adc_clk);
    sys_ren = 1'b0;
    await_ack();
    data = sys_rdata;
  endtask

  // Sign kept, magnitude inverted, then sign extended
  function automatic logic [SYS_DW-1:0] adc_expect(input logic [ADC_DW-1:0] pins);
    logic [ADC_DW-1:0] conv;
    conv = pins ^ 16'h7fff;
    return {{(SYS_DW-ADC_DW){conv[ADC_DW-1]}}, conv};
  endfunction

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic reset_state();
    int high_cnt [PDM_CHN];
    int cdcs_cnt;
    cdcs_cnt = 0;
    foreach (high_cnt[n]) high_cnt[n] = 0;
    check_dac_code(dac_dat[0], IDLE_EXP, "DAC 0 code after reset");
    check_dac_code(dac_dat[1], IDLE_EXP, "DAC 1 code after reset");
    check_word(sys_rdata, '0, "Read data after reset");
    // No PDM pulses with zero configuration
    repeat (300) begin
      @(negedge adc_clk);
      for (int n = 0; n < PDM_CHN; n++) high_cnt[n] += dac_pwm[n];
      cdcs_cnt += adc_cdcs;
    end
    for (int n = 0; n < PDM_CHN; n++) check_pulse_count(high_cnt[n], 0, "PDM pulses after reset");
    check_pulse_count(cdcs_cnt, 300, "Stabilizer enable high cycles");
  endtask

  task automatic id_and_unmapped();
    logic [SYS_DW-1:0] rd;
    bus_read(REG_ID, 20'h0, rd);
    check_word(rd, ID_WORD, "ID word");
    bus_read(REG_ID, 20'h4, rd);
    check_word(rd, FEATURE_EXP, "Feature word");
    bus_read(REG_ID, 20'h8, rd);
    check_word(rd, '0, "Empty ID offset");
    // Unused region and unused offsets in mapped regions
    bus_read(4'd9, 20'h0, rd);
    check_word(rd, '0, "Unmapped region 9");
    bus_read(4'd15, 20'h10, rd);
    check_word(rd, '0, "Unmapped region 15");
    bus_read(REG_PDM, 20'h40, rd);
    check_word(rd, '0, "Unused PDM offset");
    bus_read(REG_ADC, 20'h8, rd);
    check_word(rd, '0, "Unused ADC offset");
    // Writes to unmapped or read only space are still acked
    bus_write(4'd9, 20'h0, 32'hdead_beef);
    bus_write(REG_ADC, 20'h0, 32'h1234_5678);
    // Neither write may reach a writable region
    bus_read(REG_PDM, 20'h0, rd);
    check_word(rd, '0, "PDM config after foreign writes");
    bus_read(REG_DAC, 20'h0, rd);
    check_word(rd, '0, "DAC value after foreign writes");
    check_dac_code(dac_dat[0], IDLE_EXP, "DAC 0 code after foreign writes");
  endtask

  task automatic adc_conversion();
    logic [SYS_DW-1:0] rd;
    logic [ADC_DW-1:0] pins [ADC_CHN];
    repeat (16) begin
      for (int n = 0; n < ADC_CHN; n++) begin
        pins[n]    = ADC_DW'(draw_bits(ADC_DW));
        adc_dat[n] = pins[n];
      end
      repeat (2) @(negedge adc_clk);
      for (int n = 0; n < ADC_CHN; n++) begin
        bus_read(REG_ADC, SYS_OFFSET_W'(4 * n), rd);
        check_word(rd, adc_expect(pins[n]), "ADC sample");
      end
    end
  endtask

  task automatic dac_values();
    logic [SYS_DW-1:0] rd;
    logic [DAC_DW-1:0] val;
    logic [DAC_DW-1:0] exp_code [DAC_CHN];
    int                ch;
    foreach (exp_code[n]) exp_code[n] = IDLE_EXP;
    for (int i = 0; i < 12; i++) begin
      ch  = i % DAC_CHN;
      val = DAC_DW'(draw_bits(DAC_DW));
      bus_write(REG_DAC, SYS_OFFSET_W'(4 * ch), {{(SYS_DW-DAC_DW){val[DAC_DW-1]}}, val});
      // Output code, the other channel unchanged
      exp_code[ch] = val ^ IDLE_EXP;
      repeat (2) @(negedge adc_clk);
      for (int n = 0; n < DAC_CHN; n++) check_dac_code(dac_dat[n], exp_code[n], "DAC code");
      bus_read(REG_DAC, SYS_OFFSET_W'(4 * ch), rd);
      check_word(rd, {{(SYS_DW-DAC_DW){val[DAC_DW-1]}}, val}, "DAC readback");
    end
  endtask

  task automatic pdm_duty();
    logic [SYS_DW-1:0] rd;
    logic [SYS_DW-1:0] upper;
    logic [PDM_DW-1:0] cfg [PDM_CHN];
    int                high_cnt [PDM_CHN];
    for (int r = 0; r < 3; r++) begin
      // Edge values first, then random ones
      cfg[0] = 8'd0;
      cfg[1] = 8'd1;
      cfg[2] = 8'd128;
      cfg[3] = 8'd255;
      if (r > 0) begin
        for (int n = 0; n < PDM_CHN; n++) cfg[n] = PDM_DW'(draw_bits(PDM_DW));
      end
      // Upper write bits are random and must be dropped
      for (int n = 0; n < PDM_CHN; n++) begin
        upper = draw_bits(SYS_DW - PDM_DW);
        bus_write(REG_PDM, SYS_OFFSET_W'(4 * n), {upper[SYS_DW-PDM_DW-1:0], cfg[n]});
      end
      for (int n = 0; n < PDM_CHN; n++) begin
        bus_read(REG_PDM, SYS_OFFSET_W'(4 * n), rd);
        check_word(rd, {{(SYS_DW-PDM_DW){1'b0}}, cfg[n]}, "PDM readback");
      end
      repeat (4) @(negedge adc_clk);
      foreach (high_cnt[n]) high_cnt[n] = 0;
      repeat (256) begin
        @(negedge adc_clk);
        for (int n = 0; n < PDM_CHN; n++) high_cnt[n] += dac_pwm[n];
      end
      for (int n = 0; n < PDM_CHN; n++) check_pulse_count(high_cnt[n], cfg[n], "PDM duty");
    end
  endtask

  initial begin
    lfsr_state = 32'h9a8e;
    adc_dat    = '0;
    sys_addr   = '0;
    sys_wdata  = '0;
    sys_wen    = 1'b0;
    sys_ren    = 1'b0;
    wait_reset_release();
    reset_state();
    id_and_unmapped();
    adc_conversion();
    dac_values();
    pdm_duty();
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
design/rp_pkg.sv
design/sys_bus_decoder.sv
design/adc_frontend.sv
design/dac_backend.sv
design/pdm_dac.sv
design/rp_top.sv
tests/tb_clock.sv
tests/tb_rp_top.sv
